//--- build.f
design/lsu_pkg.sv
design/axi_lite_pkg.sv
design/data_cache.sv
design/load_store_unit.sv
design/lsu_top.sv
dv/axi_mem_slave.sv
dv/lsu_asserts.sv
dv/lsu_tb.sv

//--- dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    localparam waddr_t    uncached_mask = 29'h0400_0000; // Same region as lsu_top.
    localparam waddr_t    fault_mask    = 29'h0200_0000;
    localparam axi_prot_t data_prot     = 3'b000; // Unprivileged secure data access.
    localparam int        cache_lines   = 64;
    localparam int        num_ops       = 300;
    localparam int        cycle_limit   = num_ops * 40;

    logic      clk;
    logic      rst;
    logic      req_valid;
    logic      req_store;
    waddr_t    addr;
    data_t     store_data;
    strb_t     store_mask;
    logic      done;
    data_t     load_data;
    logic      access_fault;
    axi_addr_t araddr;
    logic      arvalid;
    logic      arready;
    axi_prot_t arprot;
    data_t     rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    axi_addr_t awaddr;
    logic      awvalid;
    logic      awready;
    axi_prot_t awprot;
    data_t     wdata;
    strb_t     wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;

    logic [31:0] lfsr_state = 32'ha753e97f;
    data_t       shadow [waddr_t];     // Byte-exact copy of memory.
    logic        tag_valid [cache_lines];
    waddr_t      tag_addr [cache_lines];
    waddr_t      pool [12];
    int          cycle_count  = 0;
    int          data_errors  = 0;
    int          flag_errors  = 0;
    int          count_errors = 0;
    int          bus_errors   = 0;

    lsu_top dut0 (.*);

    axi_mem_slave #(.FAULT_MASK(fault_mask)) mem0 (.*);

    bind load_store_unit lsu_asserts asserts0 (
        .clk(clk), .rst(rst), .req_valid(req_valid), .done(done), .state(state),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wvalid(wvalid), .wready(wready), .bresp(bresp), .bvalid(bvalid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the operations did not finish within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic data_t init_word(input waddr_t a);
        return {3'b000, a, 3'b000, ~a};
    endfunction

    task automatic compare_data(input string what, input data_t got, input data_t exp);
        if (got !== exp) begin
            data_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(input string what, input axi_addr_t got, input axi_addr_t exp);
        if (got !== exp) begin
            bus_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_prot(input string what, input axi_prot_t got, input axi_prot_t exp);
        if (got !== exp) begin
            bus_errors++;
            $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_strb(input string what, input strb_t got, input strb_t exp);
        if (got !== exp) begin
            bus_errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Issues one request and checks the handshakes seen up to done against the model.
    task automatic run_op(input logic store, input waddr_t a, input data_t d, input strb_t m);
        int        ar_n;
        int        r_n;
        int        rr_n;
        int        aw_n;
        int        w_n;
        int        idx;
        logic      line_hit;
        logic      cacheable;
        logic      faulting;
        logic      expect_hit;
        axi_addr_t got_araddr;
        axi_prot_t got_arprot;
        axi_addr_t got_awaddr;
        axi_prot_t got_awprot;
        data_t     got_wdata;
        strb_t     got_wstrb;
        ar_n = 0;
        r_n  = 0;
        rr_n = 0;
        aw_n = 0;
        w_n  = 0;
        got_araddr = '0;
        got_arprot = '0;
        got_awaddr = '0;
        got_awprot = '0;
        got_wdata  = '0;
        got_wstrb  = '0;
        @(posedge clk);
        #1;
        req_valid  = 1'b1;
        req_store  = store;
        addr       = a;
        store_data = d;
        store_mask = m;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        do begin
            @(negedge clk);
            if (arvalid && arready) begin
                ar_n++;
                got_araddr = araddr;
                got_arprot = arprot;
            end
            if (rready) begin
                rr_n++;
            end
            if (rvalid && rready) begin
                r_n++;
            end
            if (awvalid && awready) begin
                aw_n++;
                got_awaddr = awaddr;
                got_awprot = awprot;
            end
            if (wvalid && wready) begin
                w_n++;
                got_wdata = wdata;
                got_wstrb = wstrb;
            end
        end while (!done);
        idx       = a[$clog2(cache_lines)-1:0];
        line_hit  = tag_valid[idx] && tag_addr[idx] == a;
        cacheable = (a & uncached_mask) == '0;
        faulting  = (a & fault_mask) != '0;
        if (store) begin
            compare_count("AR handshakes on store", ar_n, 0);
            compare_count("rready cycles on store", rr_n, 0);
            compare_count("AW handshakes", aw_n, 1);
            compare_count("W handshakes", w_n, 1);
            compare_addr("awaddr", got_awaddr, {a, 3'b000});
            compare_prot("awprot", got_awprot, data_prot);
            compare_data("wdata", got_wdata, d);
            compare_strb("wstrb", got_wstrb, m);
            compare_flag("bready", bready, 1'b1);
            compare_flag("access_fault on store", access_fault, 1'b0);
            for (int i = 0; i < xlen / 8; i++) begin
                if (m[i]) begin
                    shadow[a][i*8 +: 8] = d[i*8 +: 8];
                end
            end
            if (cacheable && (line_hit || m == '1)) begin
                tag_valid[idx] = 1'b1;
                tag_addr[idx]  = a;
            end
        end else begin
            expect_hit = cacheable && line_hit;
            compare_flag("hit", ar_n == 0, expect_hit);
            compare_count("AR handshakes on load", ar_n, expect_hit ? 0 : 1);
            compare_count("R handshakes on load", r_n, expect_hit ? 0 : 1);
            compare_count("AW handshakes on load", aw_n + w_n, 0);
            if (expect_hit) begin
                compare_count("rready cycles on hit", rr_n, 0);
            end else begin
                compare_addr("araddr", got_araddr, {a, 3'b000});
                compare_prot("arprot", got_arprot, data_prot);
            end
            compare_flag("access_fault", access_fault, faulting && !expect_hit);
            if (!faulting || expect_hit) begin
                compare_data("load_data", load_data, shadow[a]);
            end
            if (cacheable && !expect_hit && !faulting) begin
                tag_valid[idx] = 1'b1;
                tag_addr[idx]  = a;
            end
        end
    endtask

    initial begin
        logic  op_store;
        int    pick;
        int    gap;
        data_t op_data;
        strb_t op_mask;
        int    total;
        rst        = 1'b1;
        req_valid  = 1'b0;
        req_store  = 1'b0;
        addr       = '0;
        store_data = '0;
        store_mask = '0;
        pool = '{29'h10, 29'h11, 29'h12, 29'h13, 29'h20, 29'h21, 29'h35, 29'h50,
                 29'h0400_0014, 29'h0400_0015, 29'h0200_0016, 29'h0200_0017};
        foreach (pool[i]) begin
            shadow[pool[i]]   = init_word(pool[i]);
            mem0.mem[pool[i]] = init_word(pool[i]);
        end
        for (int i = 0; i < cache_lines; i++) begin
            tag_valid[i] = 1'b0;
            tag_addr[i]  = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        run_op(1'b0, pool[0], '0, '0);
        run_op(1'b0, pool[0], '0, '0);
        run_op(1'b0, pool[7], '0, '0);     // Alias of pool[0].
        run_op(1'b0, pool[0], '0, '0);
        run_op(1'b1, pool[6], 64'h0123_4567_89ab_cdef, 8'h0f);
        run_op(1'b0, pool[6], '0, '0);
        run_op(1'b0, pool[8], '0, '0);
        run_op(1'b0, pool[8], '0, '0);
        run_op(1'b0, pool[10], '0, '0);
        run_op(1'b0, pool[10], '0, '0);

        for (int n = 0; n < num_ops - 10; n++) begin
            op_store = rand_bits(1);
            pick     = op_store ? rand_bits(4) % 10 : rand_bits(4) % 12; // No stores to faults.
            op_data  = {rand_bits(32), rand_bits(32)};
            op_mask  = rand_bits(1) ? '1 : strb_t'(rand_bits(8));
            gap      = rand_bits(2);
            repeat (gap) @(posedge clk);
            run_op(op_store, pool[pick], op_data, op_mask);
        end

        repeat (2) @(posedge clk);
        total = data_errors + flag_errors + count_errors + bus_errors
              + dut0.lsu0.asserts0.failures;
        $display("Error counts: data %0d, flag %0d, count %0d, bus %0d, assertion %0d",
                 data_errors, flag_errors, count_errors, bus_errors,
                 dut0.lsu0.asserts0.failures);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- dv/lsu_asserts.sv
`timescale 1ns/1ps

module lsu_asserts (
    input logic                    clk,
    input logic                    rst,
    input logic                    req_valid,
    input logic                    done,
    input lsu_pkg::lsu_state_t     state,
    input axi_lite_pkg::axi_addr_t araddr,
    input logic                    arvalid,
    input logic                    arready,
    input axi_lite_pkg::axi_addr_t awaddr,
    input logic                    awvalid,
    input logic                    awready,
    input logic                    wvalid,
    input logic                    wready,
    input axi_lite_pkg::axi_resp_t bresp,
    input logic                    bvalid
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    int failures = 0;

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            $error("AR request dropped or changed while arready was low");
            failures++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            $error("AW request dropped or changed while awready was low");
            failures++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
        else begin
            $error("W data dropped while wready was low");
            failures++;
        end

    addr_known: assert property (@(posedge clk) disable iff (rst)
        (arvalid |-> !$isunknown(araddr)) and (awvalid |-> !$isunknown(awaddr)))
        else begin
            $error("Bus address is unknown while its valid is high");
            failures++;
        end

    b_okay: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> bresp == resp_okay)
        else begin
            $error("Write response is not OKAY");
            failures++;
        end

    req_when_free: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> state == idle || done)
        else begin
            $error("Request raised while the unit was busy");
            failures++;
        end

endmodule

//--- dv/axi_mem_slave.sv
`timescale 1ns/1ps

module axi_mem_slave #(
    parameter lsu_pkg::waddr_t FAULT_MASK = '0
) (
    input  logic                    clk,
    input  logic                    rst,
    input  axi_lite_pkg::axi_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output lsu_pkg::data_t          rdata,
    output axi_lite_pkg::axi_resp_t rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  axi_lite_pkg::axi_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  lsu_pkg::data_t          wdata,
    input  lsu_pkg::strb_t          wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output axi_lite_pkg::axi_resp_t bresp,
    output logic                    bvalid,
    input  logic                    bready
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    data_t       mem [waddr_t]; // Word memory that the testbench fills.
    logic [31:0] lfsr_state = 32'ha753e97f;
    waddr_t      r_addr;
    waddr_t      w_addr;
    data_t       w_data;
    strb_t       w_strb;
    logic        r_busy;
    logic        aw_got;
    logic        w_got;
    logic        b_next;
    logic        b_hold;
    int unsigned r_wait;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid  = 1'b0;
        rdata   = '0;
        rresp   = resp_okay;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        bresp   = resp_okay;
        r_busy  = 1'b0;
        aw_got  = 1'b0;
        w_got   = 1'b0;
        r_wait  = 0;
        forever begin
            @(posedge clk);
            b_next = 1'b0;
            b_hold = 1'b0;
            if (rst) begin
                r_busy = 1'b0;
                aw_got = 1'b0;
                w_got  = 1'b0;
            end else begin
                b_hold = bvalid && !bready; // Response waits for bready.
                if (rvalid && rready) begin
                    r_busy = 1'b0;
                end
                if (arvalid && arready) begin
                    r_busy = 1'b1;
                    r_addr = araddr[31:3];
                    r_wait = rand_bits(2); // Response delay of 0 to 3 cycles.
                end
                if (awvalid && awready) begin
                    aw_got = 1'b1;
                    w_addr = awaddr[31:3];
                end
                if (wvalid && wready) begin
                    w_got  = 1'b1;
                    w_data = wdata;
                    w_strb = wstrb;
                end
                if (aw_got && w_got) begin
                    if (!mem.exists(w_addr)) begin
                        mem[w_addr] = '0;
                    end
                    for (int i = 0; i < xlen / 8; i++) begin
                        if (w_strb[i]) begin
                            mem[w_addr][i*8 +: 8] = w_data[i*8 +: 8];
                        end
                    end
                    aw_got = 1'b0;
                    w_got  = 1'b0;
                    b_next = 1'b1;
                end
            end
            #1;
            arready = !r_busy && rand_bits(1);
            awready = !aw_got && rand_bits(1);
            wready  = !w_got && rand_bits(1);
            bvalid  = b_next || b_hold;
            if (b_next) begin
                bresp = ((w_addr & FAULT_MASK) != '0) ? resp_slverr : resp_okay;
            end
            if (!r_busy) begin
                rvalid = 1'b0;
            end else if (!rvalid) begin
                if (r_wait == 0) begin
                    rvalid = 1'b1;
                    rdata  = mem.exists(r_addr) ? mem[r_addr] : '0;
                    rresp  = ((r_addr & FAULT_MASK) != '0) ? resp_slverr : resp_okay;
                end else begin
                    r_wait--;
                end
            end
        end
    end

endmodule

//--- design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
    parameter lsu_pkg::waddr_t UNCACHEABLE_MASK = 29'h0400_0000,
    parameter int              CACHE_LINES      = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic                    req_store,
    input  lsu_pkg::waddr_t         addr,
    input  lsu_pkg::data_t          store_data,
    input  lsu_pkg::strb_t          store_mask,
    output logic                    done,
    output lsu_pkg::data_t          load_data,
    output logic                    access_fault,
    output axi_lite_pkg::axi_addr_t araddr,
    output logic                    arvalid,
    input  logic                    arready,
    output axi_lite_pkg::axi_prot_t arprot,
    input  lsu_pkg::data_t          rdata,
    input  axi_lite_pkg::axi_resp_t rresp,
    input  logic                    rvalid,
    output logic                    rready,
    output axi_lite_pkg::axi_addr_t awaddr,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_lite_pkg::axi_prot_t awprot,
    output lsu_pkg::data_t          wdata,
    output lsu_pkg::strb_t          wstrb,
    output logic                    wvalid,
    input  logic                    wready,
    input  axi_lite_pkg::axi_resp_t bresp,
    input  logic                    bvalid,
    output logic                    bready
);

    load_store_unit #(
        .UNCACHEABLE_MASK(UNCACHEABLE_MASK),
        .CACHE_LINES     (CACHE_LINES)
    ) lsu0 (
        .clk, .rst,
        .req_valid, .req_store, .addr, .store_data, .store_mask,
        .done, .load_data, .access_fault,
        .araddr, .arvalid, .arready, .arprot,
        .rdata, .rresp, .rvalid, .rready,
        .awaddr, .awvalid, .awready, .awprot,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready
    );

endmodule

//--- design/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit #(
    parameter lsu_pkg::waddr_t UNCACHEABLE_MASK = '0,
    parameter int              CACHE_LINES      = 64
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic                    req_store,
    input  lsu_pkg::waddr_t         addr,
    input  lsu_pkg::data_t          store_data,
    input  lsu_pkg::strb_t          store_mask,
    output logic                    done,
    output lsu_pkg::data_t          load_data,
    output logic                    access_fault,
    output axi_lite_pkg::axi_addr_t araddr,
    output logic                    arvalid,
    input  logic                    arready,
    output axi_lite_pkg::axi_prot_t arprot,
    input  lsu_pkg::data_t          rdata,
    input  axi_lite_pkg::axi_resp_t rresp,
    input  logic                    rvalid,
    output logic                    rready,
    output axi_lite_pkg::axi_addr_t awaddr,
    output logic                    awvalid,
    input  logic                    awready,
    output axi_lite_pkg::axi_prot_t awprot,
    output lsu_pkg::data_t          wdata,
    output lsu_pkg::strb_t          wstrb,
    output logic                    wvalid,
    input  logic                    wready,
    input  axi_lite_pkg::axi_resp_t bresp,
    input  logic                    bvalid,
    output logic                    bready
);
    import lsu_pkg::*;
    import axi_lite_pkg::*;

    lsu_state_t state;
    lsu_state_t follow_state;

    waddr_t addr_buf;
    data_t  store_data_buf;
    strb_t  store_mask_buf;
    logic   uncacheable_q;

    waddr_t cache_raddr;
    data_t  cache_rdata;
    logic   cache_lookup_valid;
    logic   cache_we;
    data_t  cache_wdata;

    logic accept;
    logic load_hit;
    logic aw_pending;
    logic w_pending;
    logic aw_done;
    logic w_done;
    logic store_state;
    logic store_finish;

    assign accept       = req_valid && (state == idle || done);
    assign cache_raddr  = accept ? addr : addr_buf;
    assign load_hit     = cache_lookup_valid && !uncacheable_q;
    assign aw_done      = (awvalid && awready) || aw_pending;
    assign w_done       = (wvalid && wready) || w_pending;
    assign store_state  = (state == store_check) || (state == store_wait);
    assign store_finish = store_state && aw_done && w_done;

    // Where the FSM goes once the current operation is done.
    assign follow_state = !accept ? idle : (req_store ? store_check : load_check);

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_buf       <= addr;
            store_data_buf <= store_data;
            store_mask_buf <= store_mask;
        end
        uncacheable_q <= (cache_raddr & UNCACHEABLE_MASK) != '0; // Lines up with the lookup.
    end

    data_cache #(
        .CACHE_LINES(CACHE_LINES)
    ) cache0 (
        .clk,
        .rst,
        .raddr       (cache_raddr),
        .rdata       (cache_rdata),
        .lookup_valid(cache_lookup_valid),
        .write_enable(cache_we),
        .waddr       (addr_buf),
        .wdata       (cache_wdata)
    );

    always_comb begin
        cache_we    = 1'b0;
        cache_wdata = rdata;
        case (state)
            load_wait: begin
                cache_we = rvalid && (rresp == resp_okay) && !uncacheable_q; // Faults never fill.
            end
            store_check: begin
                cache_we = !uncacheable_q && (cache_lookup_valid || store_mask_buf == '1);
                for (int i = 0; i < xlen / 8; i++) begin
                    cache_wdata[i*8 +: 8] = store_mask_buf[i] ? store_data_buf[i*8 +: 8]
                                                              : cache_rdata[i*8 +: 8];
                end
            end
            default: begin
                cache_we = 1'b0;
            end
        endcase
    end

    always_comb begin
        done         = 1'b0;
        load_data    = '0;
        access_fault = 1'b0;
        case (state)
            load_check: begin
                done      = load_hit;
                load_data = cache_rdata;
            end
            load_wait: begin
                done         = rvalid;
                load_data    = rdata;
                access_fault = rvalid && (rresp != resp_okay);
            end
            store_check, store_wait: begin
                done = aw_done && w_done;
            end
            default: begin
                done = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle:        state <= follow_state;
                load_check: begin
                    if (load_hit) begin
                        state <= follow_state;
                    end else if (arready) begin
                        state <= load_wait; // Otherwise hold AR.
                    end
                end
                load_wait: begin
                    if (rvalid) begin
                        state <= follow_state;
                    end
                end
                store_check: state <= done ? follow_state : store_wait;
                store_wait: begin
                    if (done) begin
                        state <= follow_state;
                    end
                end
                default:     state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
        end else if (accept && req_store) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
        end else begin
            if (awready) begin
                awvalid <= 1'b0;
            end
            if (wready) begin
                wvalid <= 1'b0;
            end
        end
    end

    // AW and W may finish in either order.
    always_ff @(posedge clk) begin
        if (rst || store_finish) begin
            aw_pending <= 1'b0;
            w_pending  <= 1'b0;
        end else begin
            if (awvalid && awready) begin
                aw_pending <= 1'b1;
            end
            if (wvalid && wready) begin
                w_pending <= 1'b1;
            end
        end
    end

    assign arvalid = (state == load_check) && !load_hit;
    assign araddr  = {addr_buf, 3'b000};
    assign arprot  = '0;
    assign rready  = state == load_wait;

    assign awaddr = {addr_buf, 3'b000};
    assign awprot = '0;
    assign wdata  = store_data_buf;
    assign wstrb  = store_mask_buf;
    assign bready = 1'b1; // Write responses are accepted and dropped.

endmodule

//--- design/data_cache.sv
`timescale 1ns/1ps

module data_cache #(
    parameter int CACHE_LINES = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  lsu_pkg::waddr_t raddr,
    output lsu_pkg::data_t  rdata,
    output logic            lookup_valid,
    input  logic            write_enable,
    input  lsu_pkg::waddr_t waddr,
    input  lsu_pkg::data_t  wdata
);
    import lsu_pkg::*;

    localparam int idx_w = $clog2(CACHE_LINES);
    localparam int tag_w = $bits(waddr_t) - idx_w;

    typedef logic [idx_w-1:0] index_t;
    typedef logic [tag_w-1:0] tag_t;

    logic [CACHE_LINES-1:0] line_valid;
    tag_t                   tag_mem [CACHE_LINES];
    data_t                  data_mem [CACHE_LINES];

    index_t r_idx;
    index_t w_idx;
    logic   fwd;
    logic   valid_q;
    tag_t   tag_q;
    tag_t   rtag_q;

    assign r_idx = raddr[idx_w-1:0];
    assign w_idx = waddr[idx_w-1:0];
    assign fwd   = write_enable && (w_idx == r_idx); // Lookup sees the write of this edge.

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
            valid_q    <= 1'b0;
        end else begin
            if (write_enable) begin
                line_valid[w_idx] <= 1'b1;
            end
            valid_q <= fwd ? 1'b1 : line_valid[r_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            tag_mem[w_idx]  <= waddr[$bits(waddr_t)-1:idx_w];
            data_mem[w_idx] <= wdata;
        end
        tag_q  <= fwd ? waddr[$bits(waddr_t)-1:idx_w] : tag_mem[r_idx];
        rdata  <= fwd ? wdata : data_mem[r_idx];
        rtag_q <= raddr[$bits(waddr_t)-1:idx_w];
    end

    // Hit when the stored tag matches the address looked up last cycle.
    assign lookup_valid = valid_q && (tag_q == rtag_q);

endmodule

//--- design/axi_lite_pkg.sv
package axi_lite_pkg;

    localparam int axi_addr_width = 32;

    typedef logic [axi_addr_width-1:0] axi_addr_t;
    typedef logic [2:0] axi_prot_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_t;

endpackage

//--- design/lsu_pkg.sv
package lsu_pkg;

    localparam int xlen = 64;

    // One data word of the core.
    typedef logic [xlen-1:0] data_t;

    // One strobe bit per data byte.
    typedef logic [xlen/8-1:0] strb_t;

    // Byte address shifted right by three.
    typedef logic [28:0] waddr_t;

    typedef enum logic [2:0] {
        idle,
        load_check,
        load_wait,
        store_check,
        store_wait
    } lsu_state_t;

endpackage
